/* Makefile */
TOP := rom_load_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* build.f */
hdl/rom_load_pkg.sv
hdl/rom_dwnld.sv
hdl/sdram_prog_port.sv
hdl/prom_store.sv
hdl/header_regs.sv
hdl/rom_load_top.sv
dv/rom_load_props.sv
dv/rom_load_tb.sv

/* dv/rom_load_props.sv */
////////////////////
// write handshake assertions for the ROM download decoder
////////////////////
`timescale 1ns/1ps
`default_nettype none

module rom_load_props (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic downloading,
    input wire logic ioctl_wr,
    input wire logic ioctl_ready,
    input wire logic prog_we,
    input wire logic sdram_ack
);

    // a pending SDRAM request is held until the controller acknowledges it
    req_held_a: assert property (@(posedge clk) disable iff (!rst_n)
        (prog_we && !sdram_ack && downloading) |=> prog_we)
        else $error("prog_we dropped before sdram_ack");

    // reset leaves no request pending
    reset_clear_a: assert property (@(posedge clk) !rst_n |=> !prog_we)
        else $error("prog_we high after reset");

    // the host only writes while the decoder can take a byte
    host_paced_a: assert property (@(posedge clk) disable iff (!rst_n)
        ioctl_wr |-> ioctl_ready)
        else $error("ioctl_wr pulsed while ioctl_ready was low");

endmodule

bind rom_dwnld rom_load_props props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .downloading (downloading),
    .ioctl_wr    (ioctl_wr),
    .ioctl_ready (ioctl_ready),
    .prog_we     (prog_we),
    .sdram_ack   (sdram_ack)
);

`default_nettype wire

/* dv/rom_load_tb.sv */
////////////////////
// ROM loader testbench
// random byte stream, shadow memories and read-back compare
////////////////////
`timescale 1ns/1ps
`default_nettype none

module rom_load_tb;

    localparam rom_load_pkg::ioctl_addr_t HEADER     = 25'd4;
    localparam rom_load_pkg::ioctl_addr_t BA1_START  = 25'd16;
    localparam rom_load_pkg::ioctl_addr_t BA2_START  = 25'd32;
    localparam rom_load_pkg::ioctl_addr_t BA3_START  = 25'd48;
    localparam rom_load_pkg::ioctl_addr_t PROM_START = 25'd64;
    localparam bit SWAB       = 1'b0;
    localparam int WR_LAT     = 3;
    localparam int BANK_AW    = 6;
    localparam int PROM_AW    = 6;
    localparam int N_BYTES    = 4 + 64 + 16;
    localparam int TIMEOUT    = 50;
    localparam int LOAD_LIMIT = 2000;
    // byte kinds returned by the reference function
    localparam int K_HDR   = 0;
    localparam int K_SDRAM = 1;
    localparam int K_PROM  = 2;

    logic                      clk;
    logic                      rst_n;
    logic                      downloading;
    rom_load_pkg::ioctl_addr_t ioctl_addr;
    rom_load_pkg::byte_t       ioctl_dout;
    logic                      ioctl_wr;
    logic                      ioctl_ready;
    logic                      hdr_done;
    logic [2:0]                hdr_raddr;
    rom_load_pkg::byte_t       hdr_rdata;
    rom_load_pkg::prog_addr_t  prom_raddr;
    rom_load_pkg::byte_t       prom_rdata;
    rom_load_pkg::bank_t       sdram_rba;
    rom_load_pkg::prog_addr_t  sdram_raddr;
    rom_load_pkg::word_t       sdram_rdata;

    // the image as sent and the contents each store should end up with
    rom_load_pkg::byte_t img [0:N_BYTES-1];
    rom_load_pkg::word_t exp_sdram [0:(4<<BANK_AW)-1];
    rom_load_pkg::byte_t exp_prom [0:(1<<PROM_AW)-1];
    logic                load_done;
    int                  seed;

    rom_load_top #(
        .PROM_START (PROM_START),
        .BA1_START  (BA1_START),
        .BA2_START  (BA2_START),
        .BA3_START  (BA3_START),
        .HEADER     (HEADER),
        .SWAB       (SWAB),
        .BANK_AW    (BANK_AW),
        .PROM_AW    (PROM_AW),
        .HDR_AW     (3),
        .WR_LAT     (WR_LAT)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .ioctl_ready (ioctl_ready),
        .hdr_done    (hdr_done),
        .hdr_raddr   (hdr_raddr),
        .hdr_rdata   (hdr_rdata),
        .prom_raddr  (prom_raddr),
        .prom_rdata  (prom_rdata),
        .sdram_rba   (sdram_rba),
        .sdram_raddr (sdram_raddr),
        .sdram_rdata (sdram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    ////////////////////
    // reference model and checks

    // where a host byte should land: kind, bank, word or PROM address, and lane
    function automatic void ref_place(input rom_load_pkg::ioctl_addr_t a, output int kind,
            output rom_load_pkg::bank_t ba, output rom_load_pkg::prog_addr_t wa,
            output logic low_lane);
        rom_load_pkg::ioctl_addr_t rel;
        rom_load_pkg::ioctl_addr_t start;
        rom_load_pkg::ioctl_addr_t off;
        rel   = a - HEADER;
        ba    = 2'd0;
        start = '0;
        if (rel >= BA1_START) begin
            ba    = 2'd1;
            start = BA1_START;
        end
        if (rel >= BA2_START) begin
            ba    = 2'd2;
            start = BA2_START;
        end
        if (rel >= BA3_START) begin
            ba    = 2'd3;
            start = BA3_START;
        end
        off      = rel - start;
        low_lane = off[0] ^ SWAB;
        if (a < HEADER) begin
            kind = K_HDR;
            wa   = a[21:0];
        end else if (rel >= PROM_START) begin
            kind = K_PROM;
            wa   = rel[21:0];
        end else begin
            kind = K_SDRAM;
            wa   = off[22:1];
        end
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_byte(input string name, input rom_load_pkg::byte_t got,
            input rom_load_pkg::byte_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input rom_load_pkg::word_t got,
            input rom_load_pkg::word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    ////////////////////
    // host side

    // one host byte, with the shadow memories updated from the reference
    task automatic send_byte(input rom_load_pkg::ioctl_addr_t a, input rom_load_pkg::byte_t d);
        int                       kind;
        int                       cnt;
        rom_load_pkg::bank_t      ba;
        rom_load_pkg::prog_addr_t wa;
        logic                     low_lane;
        logic [BANK_AW+1:0]       idx;
        ref_place(a, kind, ba, wa, low_lane);
        cnt = 0;
        while (!ioctl_ready) begin
            @(posedge clk);
            #2;
            cnt++;
            if (cnt > TIMEOUT) fail_run("timed out waiting for ioctl_ready before a write");
        end
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #2;
        ioctl_wr = 1'b0;
        if (kind == K_SDRAM) begin
            idx = {ba, wa[BANK_AW-1:0]};
            if (low_lane) begin
                exp_sdram[idx][7:0] = d;
            end else begin
                exp_sdram[idx][15:8] = d;
            end
            // the request is now pending, so the host is held off
            check_flag("ioctl_ready", ioctl_ready, 1'b0);
            cnt = 0;
            while (!ioctl_ready) begin
                @(posedge clk);
                #2;
                cnt++;
                if (cnt > TIMEOUT) fail_run("ioctl_ready did not return after an SDRAM write");
            end
        end else begin
            if (kind == K_PROM) begin
                exp_prom[wa[PROM_AW-1:0]] = d;
            end
            check_flag("ioctl_ready", ioctl_ready, 1'b1);
        end
    endtask

    initial begin : stimulus
        int i;
        seed        = 60034;
        load_done   = 1'b0;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        check_flag("ioctl_ready", ioctl_ready, 1'b1);
        check_flag("hdr_done", hdr_done, 1'b0);
        downloading = 1'b1;
        for (i = 0; i < N_BYTES; i++) begin
            img[i] = 8'($random(seed));
            send_byte(25'(i), img[i]);
            // hdr_done rises with the last header byte and stays up
            check_flag("hdr_done", hdr_done, i >= int'(HEADER) - 1);
        end
        @(posedge clk);
        #2;
        downloading = 1'b0;
        @(posedge clk);
        load_done = 1'b1;
    end

    ////////////////////
    // read-back compare

    task automatic read_hdr(input logic [2:0] a, output rom_load_pkg::byte_t data);
        hdr_raddr = a;
        @(posedge clk);
        #2;
        data = hdr_rdata;
    endtask

    task automatic read_prom(input rom_load_pkg::prog_addr_t a, output rom_load_pkg::byte_t data);
        prom_raddr = a;
        @(posedge clk);
        #2;
        data = prom_rdata;
    endtask

    task automatic read_sdram(input rom_load_pkg::bank_t ba, input rom_load_pkg::prog_addr_t a,
            output rom_load_pkg::word_t data);
        sdram_rba   = ba;
        sdram_raddr = a;
        @(posedge clk);
        #2;
        data = sdram_rdata;
    endtask

    initial begin : compare
        int                        a;
        int                        k;
        int                        cnt;
        int                        kind;
        rom_load_pkg::bank_t       ba;
        rom_load_pkg::prog_addr_t  wa;
        logic                      low_lane;
        rom_load_pkg::word_t       w;
        rom_load_pkg::byte_t       b;
        rom_load_pkg::ioctl_addr_t start;
        hdr_raddr   = '0;
        prom_raddr  = '0;
        sdram_rba   = '0;
        sdram_raddr = '0;
        cnt         = 0;
        while (load_done !== 1'b1) begin
            @(posedge clk);
            #2;
            cnt++;
            if (cnt > LOAD_LIMIT) fail_run("the byte stream did not finish in time");
        end
        // every byte is read back through the port of the store it went to
        for (a = 0; a < N_BYTES; a++) begin
            ref_place(25'(a), kind, ba, wa, low_lane);
            if (kind == K_HDR) begin
                read_hdr(3'(a), b);
                check_byte("hdr_rdata", b, img[a]);
            end else if (kind == K_PROM) begin
                read_prom(wa, b);
                check_byte("prom_rdata", b, exp_prom[wa[PROM_AW-1:0]]);
            end else begin
                read_sdram(ba, wa, w);
                check_word("sdram_rdata", w, exp_sdram[{ba, wa[BANK_AW-1:0]}]);
            end
        end
        // the first byte at each bank start lands in the high lane of word 0
        for (k = 1; k < 4; k++) begin
            start = (k == 1) ? BA1_START : ((k == 2) ? BA2_START : BA3_START);
            read_sdram(2'(k), '0, w);
            check_byte("sdram_rdata[15:8]", w[15:8], img[int'(HEADER + start)]);
            check_byte("sdram_rdata[7:0]", w[7:0], img[int'(HEADER + start) + 1]);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/header_regs.sv */
////////////////////
// header register file and header-complete flag
////////////////////
`timescale 1ns/1ps
`default_nettype none

module header_regs #(
    parameter rom_load_pkg::ioctl_addr_t HEADER = 25'd4,
    parameter int                        HDR_AW = 3
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        downloading,
    input  wire logic                        header,
    input  wire logic                        ioctl_wr,
    input  wire rom_load_pkg::ioctl_addr_t   ioctl_addr,
    input  wire rom_load_pkg::byte_t         ioctl_dout,
    input  wire logic [HDR_AW-1:0]           raddr,
    output rom_load_pkg::byte_t              rdata,
    output logic                             hdr_done
);

    rom_load_pkg::byte_t regs [0:(1<<HDR_AW)-1];
    logic                hdr_wr;

    // a header byte is only taken while a load is running
    assign hdr_wr = ioctl_wr && header && downloading;

    always_ff @(posedge clk) begin
        if (hdr_wr) begin
            regs[ioctl_addr[HDR_AW-1:0]] <= ioctl_dout;
        end
        rdata <= regs[raddr];
    end

    // the last header byte marks the header as complete
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdr_done <= 1'b0;
        end else if (hdr_wr && (ioctl_addr == HEADER - 1'b1)) begin
            hdr_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/prom_store.sv */
////////////////////
// on-chip PROM, one write and one read port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module prom_store #(
    parameter int PROM_AW = 6
) (
    input  wire logic                        clk,
    input  wire logic                        prom_we,
    input  wire rom_load_pkg::prog_addr_t    waddr,
    input  wire rom_load_pkg::byte_t         wdata,
    input  wire rom_load_pkg::prog_addr_t    raddr,
    output rom_load_pkg::byte_t              rdata
);

    localparam int DEPTH = 1 << PROM_AW;

    rom_load_pkg::byte_t mem [0:DEPTH-1];
    logic [PROM_AW-1:0]  wa;
    logic [PROM_AW-1:0]  ra;

    // only the low address bits select a location, the rest wrap around
    assign wa = waddr[PROM_AW-1:0];
    assign ra = raddr[PROM_AW-1:0];

    ////////////////////
    // write side

    // one byte per strobe from the decoder
    always_ff @(posedge clk) begin
        if (prom_we) begin
            mem[wa] <= wdata;
        end
    end

    ////////////////////
    // read side

    // data follows the address by one cycle
    always_ff @(posedge clk) begin
        rdata <= mem[ra];
    end

endmodule

`default_nettype wire

/* hdl/rom_dwnld.sv */
////////////////////
// ROM download decoder
// splits the host byte stream into header, PROM and SDRAM bank writes
////////////////////
`timescale 1ns/1ps
`default_nettype none

module rom_dwnld #(
    parameter rom_load_pkg::ioctl_addr_t PROM_START = 25'd64,
    parameter rom_load_pkg::ioctl_addr_t BA1_START  = 25'd16,
    parameter rom_load_pkg::ioctl_addr_t BA2_START  = 25'd32,
    parameter rom_load_pkg::ioctl_addr_t BA3_START  = 25'd48,
    parameter rom_load_pkg::ioctl_addr_t HEADER     = 25'd4,
    parameter bit                        SWAB       = 1'b0
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        downloading,
    input  wire rom_load_pkg::ioctl_addr_t   ioctl_addr,
    input  wire rom_load_pkg::byte_t         ioctl_dout,
    input  wire logic                        ioctl_wr,
    input  wire logic                        sdram_ack,
    output rom_load_pkg::prog_addr_t         prog_addr,
    output rom_load_pkg::word_t              prog_data,
    output rom_load_pkg::mask_t              prog_mask,
    output rom_load_pkg::bank_t              prog_ba,
    output logic                             prog_we,
    output logic                             prom_we,
    output logic                             header,
    output logic                             ioctl_ready
);

    rom_load_pkg::ioctl_addr_t part_addr;
    rom_load_pkg::ioctl_addr_t offset;
    rom_load_pkg::ioctl_addr_t eff_addr;
    rom_load_pkg::bank_t       bank;
    rom_load_pkg::byte_t       data_byte;
    logic                      is_prom;
    logic                      accept;

    ////////////////////
    // address decoding

    // the header sits in front of the image and is not counted in the part address
    assign header    = downloading && (ioctl_addr < HEADER);
    assign part_addr = ioctl_addr - HEADER;
    assign is_prom   = part_addr >= PROM_START;
    assign accept    = ioctl_wr && downloading && !header;

    always_comb begin
        // highest bank whose start is not above the byte
        if (part_addr >= BA3_START) begin
            bank = 2'd3;
        end else if (part_addr >= BA2_START) begin
            bank = 2'd2;
        end else if (part_addr >= BA1_START) begin
            bank = 2'd1;
        end else begin
            bank = 2'd0;
        end
        case (bank)
            2'd1:    offset = BA1_START;
            2'd2:    offset = BA2_START;
            2'd3:    offset = BA3_START;
            default: offset = '0;
        endcase
        eff_addr = part_addr - offset;
    end

    ////////////////////
    // write strobes

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            // PROM writes need no handshake, so the strobe lasts one cycle
            prom_we <= accept && is_prom;
            // the SDRAM request stays up until the controller acknowledges it
            if (sdram_ack || !downloading) begin
                prog_we <= 1'b0;
            end
            if (accept && !is_prom) begin
                prog_we <= 1'b1;
            end
        end
    end

    // address, data and lane select of the byte being written
    always_ff @(posedge clk) begin
        if (accept) begin
            data_byte <= ioctl_dout;
            // odd bytes land in the low lane unless the pair is swapped
            prog_mask <= (eff_addr[0] ^ SWAB) ? 2'b10 : 2'b01;
            if (is_prom) begin
                prog_addr <= part_addr[21:0];
            end else begin
                prog_addr <= eff_addr[22:1];
                prog_ba   <= bank;
            end
        end
    end

    // the byte goes on both halves and the mask picks the lane
    assign prog_data = {2{data_byte}};

    // the host waits while an SDRAM request is pending
    assign ioctl_ready = !prog_we;

endmodule

`default_nettype wire

/* hdl/rom_load_pkg.sv */
////////////////////
// shared types for the ROM loader
// width typedefs and the SDRAM write controller states
////////////////////
`default_nettype none

package rom_load_pkg;

    // byte address as sent by the host, header included
    typedef logic [24:0] ioctl_addr_t;

    // one byte of the ROM image
    typedef logic [7:0] byte_t;

    // word address inside an SDRAM bank, or byte address inside the PROM
    typedef logic [21:0] prog_addr_t;

    // SDRAM data word, two byte lanes
    typedef logic [15:0] word_t;

    // active low lane enables, bit 0 low writes the low byte
    typedef logic [1:0] mask_t;

    // one of the four SDRAM banks
    typedef logic [1:0] bank_t;

    // the write controller waits in SD_WAIT for the write latency to expire
    typedef enum logic [1:0] {SD_IDLE, SD_WAIT, SD_ACK} sdram_state_t;

endpackage

`default_nettype wire

/* hdl/rom_load_top.sv */
////////////////////
// ROM loader top level
// decoder, SDRAM port, PROM and header registers
////////////////////
`timescale 1ns/1ps
`default_nettype none

module rom_load_top #(
    parameter rom_load_pkg::ioctl_addr_t PROM_START = 25'd64,
    parameter rom_load_pkg::ioctl_addr_t BA1_START  = 25'd16,
    parameter rom_load_pkg::ioctl_addr_t BA2_START  = 25'd32,
    parameter rom_load_pkg::ioctl_addr_t BA3_START  = 25'd48,
    parameter rom_load_pkg::ioctl_addr_t HEADER     = 25'd4,
    parameter bit                        SWAB       = 1'b0,
    parameter int                        BANK_AW    = 6,
    parameter int                        PROM_AW    = 6,
    parameter int                        HDR_AW     = 3,
    parameter int                        WR_LAT     = 3
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        downloading,
    input  wire rom_load_pkg::ioctl_addr_t   ioctl_addr,
    input  wire rom_load_pkg::byte_t         ioctl_dout,
    input  wire logic                        ioctl_wr,
    output logic                             ioctl_ready,
    output logic                             hdr_done,
    input  wire logic [HDR_AW-1:0]           hdr_raddr,
    output rom_load_pkg::byte_t              hdr_rdata,
    input  wire rom_load_pkg::prog_addr_t    prom_raddr,
    output rom_load_pkg::byte_t              prom_rdata,
    input  wire rom_load_pkg::bank_t         sdram_rba,
    input  wire rom_load_pkg::prog_addr_t    sdram_raddr,
    output rom_load_pkg::word_t              sdram_rdata
);

    rom_load_pkg::prog_addr_t prog_addr;
    rom_load_pkg::word_t      prog_data;
    rom_load_pkg::mask_t      prog_mask;
    rom_load_pkg::bank_t      prog_ba;
    logic                     prog_we;
    logic                     prom_we;
    logic                     header;
    logic                     sdram_ack;

    ////////////////////
    // byte decoder

    rom_dwnld #(
        .PROM_START (PROM_START),
        .BA1_START  (BA1_START),
        .BA2_START  (BA2_START),
        .BA3_START  (BA3_START),
        .HEADER     (HEADER),
        .SWAB       (SWAB)
    ) dwnld_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_ba     (prog_ba),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .header      (header),
        .ioctl_ready (ioctl_ready)
    );

    ////////////////////
    // stores

    sdram_prog_port #(
        .BANK_AW (BANK_AW),
        .WR_LAT  (WR_LAT)
    ) sdram_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_mask (prog_mask),
        .prog_ba   (prog_ba),
        .prog_we   (prog_we),
        .rba       (sdram_rba),
        .raddr     (sdram_raddr),
        .sdram_ack (sdram_ack),
        .rdata     (sdram_rdata)
    );

    // the PROM takes one of the two identical byte copies
    prom_store #(
        .PROM_AW (PROM_AW)
    ) prom_i (
        .clk     (clk),
        .prom_we (prom_we),
        .waddr   (prog_addr),
        .wdata   (prog_data[7:0]),
        .raddr   (prom_raddr),
        .rdata   (prom_rdata)
    );

    header_regs #(
        .HEADER (HEADER),
        .HDR_AW (HDR_AW)
    ) hdr_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .header      (header),
        .ioctl_wr    (ioctl_wr),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .raddr       (hdr_raddr),
        .rdata       (hdr_rdata),
        .hdr_done    (hdr_done)
    );

endmodule

`default_nettype wire

/* hdl/sdram_prog_port.sv */
////////////////////
// SDRAM programming port
// four bank word memory written after a fixed latency, with ack
////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdram_prog_port #(
    parameter int BANK_AW = 6,
    parameter int WR_LAT  = 3
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire rom_load_pkg::prog_addr_t    prog_addr,
    input  wire rom_load_pkg::word_t         prog_data,
    input  wire rom_load_pkg::mask_t         prog_mask,
    input  wire rom_load_pkg::bank_t         prog_ba,
    input  wire logic                        prog_we,
    input  wire rom_load_pkg::bank_t         rba,
    input  wire rom_load_pkg::prog_addr_t    raddr,
    output logic                             sdram_ack,
    output rom_load_pkg::word_t              rdata
);

    localparam int DEPTH = 4 * (1 << BANK_AW);
    localparam int CW    = $clog2(WR_LAT + 1);

    rom_load_pkg::sdram_state_t state;
    logic [CW-1:0]              lat_cnt;
    logic [BANK_AW+1:0]         req_idx;
    rom_load_pkg::word_t        req_data;
    rom_load_pkg::mask_t        req_mask;
    logic                       take;
    logic                       do_write;
    rom_load_pkg::word_t        mem [0:DEPTH-1];

    ////////////////////
    // request FSM

    assign take     = (state == rom_load_pkg::SD_IDLE) && prog_we;
    assign do_write = (state == rom_load_pkg::SD_WAIT) && (lat_cnt == CW'(WR_LAT));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= rom_load_pkg::SD_IDLE;
            lat_cnt <= '0;
        end else begin
            case (state)
                rom_load_pkg::SD_IDLE: begin
                    if (prog_we) begin
                        state   <= rom_load_pkg::SD_WAIT;
                        lat_cnt <= CW'(1);
                    end
                end
                rom_load_pkg::SD_WAIT: begin
                    // the count equals the cycles since the request was seen
                    if (do_write) begin
                        state <= rom_load_pkg::SD_ACK;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                // prog_we is still high here, so skip straight back to idle
                default: state <= rom_load_pkg::SD_IDLE;
            endcase
        end
    end

    // one cycle acknowledge right after the write
    assign sdram_ack = (state == rom_load_pkg::SD_ACK);

    // the request is copied so that it survives a dropped prog_we
    always_ff @(posedge clk) begin
        if (take) begin
            req_idx  <= {prog_ba, prog_addr[BANK_AW-1:0]};
            req_data <= prog_data;
            req_mask <= prog_mask;
        end
    end

    ////////////////////
    // bank memory

    always_ff @(posedge clk) begin
        if (do_write && !req_mask[0]) begin
            mem[req_idx][7:0] <= req_data[7:0];
        end
        if (do_write && !req_mask[1]) begin
            mem[req_idx][15:8] <= req_data[15:8];
        end
        rdata <= mem[{rba, raddr[BANK_AW-1:0]}];
    end

endmodule

`default_nettype wire
